// ==== axil_bridge_pkg.sv ====
`default_nettype none

package axil_bridge_pkg;

  // Bus field widths
  typedef logic [7:0] addr_t;
  typedef logic [15:0] data_t;
  typedef logic [3:0] id_t;
  typedef logic [0:0] user_t;
  typedef logic [1:0] resp_t;

  // AXI response codes in use
  localparam resp_t RESP_OKAY = 2'b00;
  localparam resp_t RESP_SLVERR = 2'b10;

  // Read memory contents
  localparam int MEM_WORDS = 64;
  localparam string MEM_FILE = "mem_init.hex";

endpackage

`default_nettype wire

// ==== skid_buf.sv ====
`default_nettype none
`timescale 1ns/100ps

module skid_buf #(
  parameter int DATA_WIDTH = 8
) (
  input  wire logic                  clk,
  input  wire logic                  i_reset,
  input  wire logic                  i_valid,
  input  wire logic [DATA_WIDTH-1:0] i_data,
  output logic                       o_ready,
  input  wire logic                  i_ready,
  output logic [DATA_WIDTH-1:0]      o_data,
  output logic                       o_valid
);

  logic                  skid_valid;
  logic [DATA_WIDTH-1:0] skid_data;
  logic                  in_xfer;
  logic                  out_free;

  // Accept while the skid slot is free
  assign o_ready  = !skid_valid;
  assign in_xfer  = i_valid && o_ready;
  // Output slot can take a new item next edge
  assign out_free = !o_valid || i_ready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_valid    <= 1'b0;
      skid_valid <= 1'b0;
    end else if (out_free) begin
      if (skid_valid) begin
        o_valid    <= 1'b1;
        skid_valid <= 1'b0;
      end else begin
        o_valid <= in_xfer;
      end
    end else if (in_xfer) begin
      skid_valid <= 1'b1;
    end
  end

  // Skid item drains first so order is kept
  always_ff @(posedge clk) begin
    if (out_free) begin
      o_data <= skid_valid ? skid_data : i_data;
    end
    if (in_xfer && !out_free) begin
      skid_data <= i_data;
    end
  end

endmodule

`default_nettype wire

// ==== sync_fifo_zl.sv ====
`default_nettype none
`timescale 1ns/100ps

module sync_fifo_zl #(
  parameter int OUTSTANDING_READS_WIDTH = 1,
  parameter int DATA_WIDTH              = 8
) (
  input  wire logic                  clk,
  input  wire logic                  i_reset,
  input  wire logic                  i_w_inc,
  input  wire logic [DATA_WIDTH-1:0] i_w_data,
  output logic                       o_w_full,
  input  wire logic                  i_r_inc,
  output logic [DATA_WIDTH-1:0]      o_r_data,
  output logic                       o_r_empty
);

  localparam int AW    = OUTSTANDING_READS_WIDTH;
  localparam int DEPTH = 1 << AW;

  logic [DATA_WIDTH-1:0] mem [DEPTH];

  // Pointers carry one extra wrap bit
  logic [AW:0] w_ptr;
  logic [AW:0] r_ptr;
  logic        do_write;
  logic        do_read;

  assign o_r_empty = (w_ptr == r_ptr);
  assign o_w_full  = (w_ptr[AW] != r_ptr[AW]) && (w_ptr[AW-1:0] == r_ptr[AW-1:0]);

  assign do_write = i_w_inc && !o_w_full;
  // A pop on an empty queue is allowed when the same cycle writes
  assign do_read  = i_r_inc && (!o_r_empty || do_write);

  // Forward the incoming item when nothing is stored yet
  assign o_r_data = o_r_empty ? i_w_data : mem[r_ptr[AW-1:0]];

  always_ff @(posedge clk) begin
    if (i_reset) begin
      w_ptr <= '0;
      r_ptr <= '0;
    end else begin
      if (do_write) begin
        w_ptr <= w_ptr + 1'b1;
      end
      if (do_read) begin
        r_ptr <= r_ptr + 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (do_write) begin
      mem[w_ptr[AW-1:0]] <= i_w_data;
    end
  end

endmodule

`default_nettype wire

// ==== axi_axil_reflect_rd.sv ====
`default_nettype none
`timescale 1ns/100ps

module axi_axil_reflect_rd #(
  parameter int OUTSTANDING_READS_WIDTH = 1
) (
  input  wire logic                  clk,
  input  wire logic                  i_reset,
  input  wire logic                  i_s_axi_arvalid,
  input  wire axil_bridge_pkg::id_t   i_s_axi_arid,
  input  wire axil_bridge_pkg::addr_t i_s_axi_araddr,
  input  wire logic [7:0]            i_s_axi_arlen,
  input  wire logic [2:0]            i_s_axi_arsize,
  input  wire logic [1:0]            i_s_axi_arburst,
  input  wire axil_bridge_pkg::user_t i_s_axi_aruser,
  output logic                       o_s_axi_arready,
  output logic                       o_s_axi_rvalid,
  output axil_bridge_pkg::id_t       o_s_axi_rid,
  output axil_bridge_pkg::data_t     o_s_axi_rdata,
  output axil_bridge_pkg::resp_t     o_s_axi_rresp,
  output axil_bridge_pkg::user_t     o_s_axi_ruser,
  output logic                       o_s_axi_rlast,
  input  wire logic                  i_s_axi_rready,
  output logic                       o_m_axil_arvalid,
  output axil_bridge_pkg::addr_t     o_m_axil_araddr,
  input  wire logic                  i_m_axil_arready,
  input  wire logic                  i_m_axil_rvalid,
  input  wire axil_bridge_pkg::data_t i_m_axil_rdata,
  input  wire axil_bridge_pkg::resp_t i_m_axil_rresp,
  output logic                       o_m_axil_rready
);

  import axil_bridge_pkg::*;

  logic ar_xfer;
  logic r_xfer;
  logic sb_ready;
  logic id_q_full;

  // Room needed in both the address buffer and the ID queue
  assign o_s_axi_arready = sb_ready && !id_q_full;
  assign ar_xfer         = i_s_axi_arvalid && o_s_axi_arready;
  assign r_xfer          = o_s_axi_rvalid && i_s_axi_rready;

  skid_buf #(
    .DATA_WIDTH($bits(addr_t))
  ) u_ar_skid (
    .clk    (clk),
    .i_reset(i_reset),
    .i_valid(ar_xfer),
    .i_data (i_s_axi_araddr),
    .o_ready(sb_ready),
    .i_ready(i_m_axil_arready),
    .o_data (o_m_axil_araddr),
    .o_valid(o_m_axil_arvalid)
  );

  // ID and USER wait here until their return comes back
  sync_fifo_zl #(
    .OUTSTANDING_READS_WIDTH(OUTSTANDING_READS_WIDTH),
    .DATA_WIDTH             ($bits(id_t) + $bits(user_t))
  ) u_id_q (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_w_inc  (ar_xfer),
    .i_w_data ({i_s_axi_arid, i_s_axi_aruser}),
    .o_w_full (id_q_full),
    .i_r_inc  (r_xfer),
    .o_r_data ({o_s_axi_rid, o_s_axi_ruser}),
    .o_r_empty()
  );

  assign o_s_axi_rvalid  = i_m_axil_rvalid;
  assign o_s_axi_rdata   = i_m_axil_rdata;
  assign o_s_axi_rresp   = i_m_axil_rresp;
  assign o_s_axi_rlast   = 1'b1;
  assign o_m_axil_rready = i_s_axi_rready;

endmodule

`default_nettype wire

// ==== axil_rd_mem.sv ====
`default_nettype none
`timescale 1ns/100ps

module axil_rd_mem (
  input  wire logic                  clk,
  input  wire logic                  i_reset,
  input  wire logic                  i_arvalid,
  input  wire axil_bridge_pkg::addr_t i_araddr,
  output logic                       o_arready,
  output logic                       o_rvalid,
  output axil_bridge_pkg::data_t     o_rdata,
  output axil_bridge_pkg::resp_t     o_rresp,
  input  wire logic                  i_rready
);

  import axil_bridge_pkg::*;

  localparam int IDX_W = $clog2(MEM_WORDS);

  data_t            mem [MEM_WORDS];
  logic [IDX_W-1:0] word_idx;
  logic             out_of_range;
  logic             ar_xfer;

  initial begin
    $readmemh(MEM_FILE, mem);
  end

  // Byte address to word index, upper bits select the error region
  assign word_idx     = i_araddr[IDX_W:1];
  assign out_of_range = |(i_araddr >> (IDX_W + 1));

  // New address only once the held return is gone or leaving
  assign o_arready = !o_rvalid || i_rready;
  assign ar_xfer   = i_arvalid && o_arready;

  always_ff @(posedge clk) begin
    if (i_reset) begin
      o_rvalid <= 1'b0;
    end else if (ar_xfer) begin
      o_rvalid <= 1'b1;
    end else if (i_rready) begin
      o_rvalid <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (ar_xfer) begin
      if (out_of_range) begin
        o_rdata <= '0;
        o_rresp <= RESP_SLVERR;
      end else begin
        o_rdata <= mem[word_idx];
        o_rresp <= RESP_OKAY;
      end
    end
  end

endmodule

`default_nettype wire

// ==== axi_rd_bridge_top.sv ====
`default_nettype none
`timescale 1ns/100ps

module axi_rd_bridge_top #(
  parameter int OUTSTANDING_READS_WIDTH = 2
) (
  input  wire logic                  clk,
  input  wire logic                  i_reset,
  input  wire logic                  i_s_axi_arvalid,
  input  wire axil_bridge_pkg::id_t   i_s_axi_arid,
  input  wire axil_bridge_pkg::addr_t i_s_axi_araddr,
  input  wire logic [7:0]            i_s_axi_arlen,
  input  wire logic [2:0]            i_s_axi_arsize,
  input  wire logic [1:0]            i_s_axi_arburst,
  input  wire axil_bridge_pkg::user_t i_s_axi_aruser,
  output logic                       o_s_axi_arready,
  output logic                       o_s_axi_rvalid,
  output axil_bridge_pkg::id_t       o_s_axi_rid,
  output axil_bridge_pkg::data_t     o_s_axi_rdata,
  output axil_bridge_pkg::resp_t     o_s_axi_rresp,
  output axil_bridge_pkg::user_t     o_s_axi_ruser,
  output logic                       o_s_axi_rlast,
  input  wire logic                  i_s_axi_rready
);

  import axil_bridge_pkg::*;

  // AXI-Lite link between bridge and memory
  logic  axil_arvalid;
  addr_t axil_araddr;
  logic  axil_arready;
  logic  axil_rvalid;
  data_t axil_rdata;
  resp_t axil_rresp;
  logic  axil_rready;

  axi_axil_reflect_rd #(
    .OUTSTANDING_READS_WIDTH(OUTSTANDING_READS_WIDTH)
  ) u_bridge (
    .clk             (clk),
    .i_reset         (i_reset),
    .i_s_axi_arvalid (i_s_axi_arvalid),
    .i_s_axi_arid    (i_s_axi_arid),
    .i_s_axi_araddr  (i_s_axi_araddr),
    .i_s_axi_arlen   (i_s_axi_arlen),
    .i_s_axi_arsize  (i_s_axi_arsize),
    .i_s_axi_arburst (i_s_axi_arburst),
    .i_s_axi_aruser  (i_s_axi_aruser),
    .o_s_axi_arready (o_s_axi_arready),
    .o_s_axi_rvalid  (o_s_axi_rvalid),
    .o_s_axi_rid     (o_s_axi_rid),
    .o_s_axi_rdata   (o_s_axi_rdata),
    .o_s_axi_rresp   (o_s_axi_rresp),
    .o_s_axi_ruser   (o_s_axi_ruser),
    .o_s_axi_rlast   (o_s_axi_rlast),
    .i_s_axi_rready  (i_s_axi_rready),
    .o_m_axil_arvalid(axil_arvalid),
    .o_m_axil_araddr (axil_araddr),
    .i_m_axil_arready(axil_arready),
    .i_m_axil_rvalid (axil_rvalid),
    .i_m_axil_rdata  (axil_rdata),
    .i_m_axil_rresp  (axil_rresp),
    .o_m_axil_rready (axil_rready)
  );

  axil_rd_mem u_mem (
    .clk      (clk),
    .i_reset  (i_reset),
    .i_arvalid(axil_arvalid),
    .i_araddr (axil_araddr),
    .o_arready(axil_arready),
    .o_rvalid (axil_rvalid),
    .o_rdata  (axil_rdata),
    .o_rresp  (axil_rresp),
    .i_rready (axil_rready)
  );

endmodule

`default_nettype wire

// ==== tb_axi_rd_bridge.sv ====
`default_nettype none
`timescale 1ns/100ps

module tb_axi_rd_bridge;

  import axil_bridge_pkg::*;

  localparam int AR_TIMEOUT    = 200;
  localparam int DRAIN_TIMEOUT = 500;
  localparam int RESET_TIMEOUT = 20;

  // Address selection for a run of reads
  localparam int MODE_LOW  = 0;
  localparam int MODE_HIGH = 1;
  localparam int MODE_ANY  = 2;

  typedef struct packed {
    id_t   id;
    user_t user;
    data_t data;
    resp_t resp;
  } ret_t;

  logic       clk;
  logic       i_reset;
  logic       i_s_axi_arvalid;
  id_t        i_s_axi_arid;
  addr_t      i_s_axi_araddr;
  logic [7:0] i_s_axi_arlen;
  logic [2:0] i_s_axi_arsize;
  logic [1:0] i_s_axi_arburst;
  user_t      i_s_axi_aruser;
  logic       i_s_axi_rready;
  logic       o_s_axi_arready;
  logic       o_s_axi_rvalid;
  id_t        o_s_axi_rid;
  data_t      o_s_axi_rdata;
  resp_t      o_s_axi_rresp;
  user_t      o_s_axi_ruser;
  logic       o_s_axi_rlast;

  data_t       model_mem [MEM_WORDS];
  ret_t        exp_q [$];
  logic [31:0] lcg_state;
  int          errors;
  int          checks;
  int          ret_cnt;
  int          arready_low_cnt;
  int          tests_run;
  int          tests_failed;
  bit          timed_out;

  axi_rd_bridge_top #(
    .OUTSTANDING_READS_WIDTH(2)
  ) dut (
    .clk            (clk),
    .i_reset        (i_reset),
    .i_s_axi_arvalid(i_s_axi_arvalid),
    .i_s_axi_arid   (i_s_axi_arid),
    .i_s_axi_araddr (i_s_axi_araddr),
    .i_s_axi_arlen  (i_s_axi_arlen),
    .i_s_axi_arsize (i_s_axi_arsize),
    .i_s_axi_arburst(i_s_axi_arburst),
    .i_s_axi_aruser (i_s_axi_aruser),
    .o_s_axi_arready(o_s_axi_arready),
    .o_s_axi_rvalid (o_s_axi_rvalid),
    .o_s_axi_rid    (o_s_axi_rid),
    .o_s_axi_rdata  (o_s_axi_rdata),
    .o_s_axi_rresp  (o_s_axi_rresp),
    .o_s_axi_ruser  (o_s_axi_ruser),
    .o_s_axi_rlast  (o_s_axi_rlast),
    .i_s_axi_rready (i_s_axi_rready)
  );

  always #2 clk = ~clk;

  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic int rand_below(input int n);
    logic [31:0] r;
    int          v;
    r = lcg_next();
    // Low bits of an LCG are weak
    v = int'(r[31:8]);
    return v % n;
  endfunction

  // Bit 7 selects the error region and bits 6 to 1 the word
  function automatic ret_t expected_return(input id_t id, input user_t user, input addr_t addr);
    ret_t r;
    r.id   = id;
    r.user = user;
    if (addr[7]) begin
      r.data = '0;
      r.resp = RESP_SLVERR;
    end else begin
      r.data = model_mem[addr[6:1]];
      r.resp = RESP_OKAY;
    end
    return r;
  endfunction

  task automatic check_field(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    assert (exp === act) else begin
      $display("Mismatch at %0t: %s expected 0x%0h, got 0x%0h", $time, name, exp, act);
      errors++;
    end
  endtask

  // Bus monitor and reference queue
  always @(posedge clk) begin
    ret_t head;
    if (!i_reset) begin
      if (!o_s_axi_arready) begin
        arready_low_cnt++;
      end
      if (i_s_axi_arvalid && o_s_axi_arready) begin
        exp_q.push_back(expected_return(i_s_axi_arid, i_s_axi_aruser, i_s_axi_araddr));
      end
      if (o_s_axi_rvalid && i_s_axi_rready) begin
        ret_cnt++;
        checks++;
        assert (exp_q.size() > 0) else begin
          $display("Read return at %0t arrived with no request outstanding", $time);
          errors++;
        end
        if (exp_q.size() > 0) begin
          head = exp_q.pop_front();
          check_field("o_s_axi_rid", 16'(head.id), 16'(o_s_axi_rid));
          check_field("o_s_axi_ruser", 16'(head.user), 16'(o_s_axi_ruser));
          check_field("o_s_axi_rdata", head.data, o_s_axi_rdata);
          check_field("o_s_axi_rresp", 16'(head.resp), 16'(o_s_axi_rresp));
          check_field("o_s_axi_rlast", 16'(1'b1), 16'(o_s_axi_rlast));
        end
      end
    end
  end

  task automatic drive_reads(input int n, input int mode, input int gap_max, input int stall_pct);
    int    started;
    int    gap;
    int    wait_cnt;
    bit    busy;
    addr_t addr;
    started  = 0;
    gap      = 0;
    wait_cnt = 0;
    busy     = 1'b0;
    while ((started < n || busy) && !timed_out) begin
      @(posedge clk);
      if (busy && !o_s_axi_arready) begin
        wait_cnt++;
        if (wait_cnt > AR_TIMEOUT) begin
          $display("Timeout: read request not accepted within %0d cycles", AR_TIMEOUT);
          errors++;
          timed_out = 1'b1;
        end
      end else if (started < n && gap == 0) begin
        addr = addr_t'(rand_below(256));
        if (mode == MODE_LOW) begin
          addr[7] = 1'b0;
        end else if (mode == MODE_HIGH) begin
          addr[7] = 1'b1;
        end
        i_s_axi_arvalid <= 1'b1;
        i_s_axi_arid    <= id_t'(rand_below(16));
        i_s_axi_aruser  <= user_t'(rand_below(2));
        i_s_axi_araddr  <= addr;
        busy     = 1'b1;
        wait_cnt = 0;
        started++;
        gap = (gap_max > 0) ? rand_below(gap_max + 1) : 0;
      end else begin
        i_s_axi_arvalid <= 1'b0;
        busy = 1'b0;
        if (gap > 0) begin
          gap--;
        end
      end
      i_s_axi_rready <= (rand_below(100) >= stall_pct);
    end
  endtask

  task automatic drain_returns();
    int cnt;
    cnt = 0;
    i_s_axi_rready <= 1'b1;
    // Queue is read between edges, after the monitor
    do begin
      @(negedge clk);
      cnt++;
    end while (exp_q.size() != 0 && cnt < DRAIN_TIMEOUT);
    // A few idle cycles expose any extra return
    repeat (2) @(negedge clk);
    checks++;
    assert (exp_q.size() == 0) else begin
      $display("Timeout: %0d read returns still missing after %0d cycles",
               exp_q.size(), DRAIN_TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end
  endtask

  task automatic report_test(input string name, input int err0, input int n);
    tests_run++;
    if (errors != err0) begin
      tests_failed++;
    end
    $display("%s: %s, %0d returns checked", name, (errors == err0) ? "ok" : "FAILED", n);
  endtask

  task automatic check_reset_state();
    int cnt;
    int err0;
    cnt  = 0;
    err0 = errors;
    while (!o_s_axi_arready && cnt < RESET_TIMEOUT) begin
      @(posedge clk);
      cnt++;
    end
    checks++;
    assert (o_s_axi_arready) else begin
      $display("o_s_axi_arready still low %0d cycles after reset", RESET_TIMEOUT);
      errors++;
      timed_out = 1'b1;
    end
    check_field("o_s_axi_rvalid", 16'(1'b0), 16'(o_s_axi_rvalid));
    report_test("reset_state", err0, 0);
  endtask

  task automatic run_test(input string name, input int n, input int mode, input int gap_max,
                          input int stall_pct, input bit need_backpressure);
    int err0;
    int ret0;
    err0            = errors;
    ret0            = ret_cnt;
    arready_low_cnt = 0;
    drive_reads(n, mode, gap_max, stall_pct);
    if (!timed_out) begin
      drain_returns();
    end
    if (need_backpressure) begin
      checks++;
      assert (arready_low_cnt > 0) else begin
        $display("o_s_axi_arready never dropped while rready stalled");
        errors++;
      end
    end
    report_test(name, err0, ret_cnt - ret0);
  endtask

  initial begin
    lcg_state       = 32'hff20_5e60;
    errors          = 0;
    checks          = 0;
    ret_cnt         = 0;
    arready_low_cnt = 0;
    tests_run       = 0;
    tests_failed    = 0;
    timed_out       = 1'b0;
    clk             = 1'b0;
    i_reset         = 1'b1;
    i_s_axi_arvalid = 1'b0;
    i_s_axi_arid    = '0;
    i_s_axi_araddr  = '0;
    i_s_axi_aruser  = '0;
    i_s_axi_rready  = 1'b0;
    // Single 16-bit INCR beat
    i_s_axi_arlen   = 8'd0;
    i_s_axi_arsize  = 3'd1;
    i_s_axi_arburst = 2'b01;
    $readmemh(MEM_FILE, model_mem);

    repeat (10) @(posedge clk);
    i_reset <= 1'b0;
    @(posedge clk);

    check_reset_state();
    if (!timed_out) begin
      run_test("in_range", 40, MODE_LOW, 3, 0, 1'b0);
    end
    if (!timed_out) begin
      run_test("out_of_range", 30, MODE_HIGH, 2, 20, 1'b0);
    end
    if (!timed_out) begin
      run_test("id_user_reflect", 60, MODE_ANY, 0, 0, 1'b0);
    end
    if (!timed_out) begin
      run_test("backpressure", 80, MODE_ANY, 1, 75, 1'b1);
    end

    $display("Summary: %0d tests run, %0d failed, %0d checks, %0d errors",
             tests_run, tests_failed, checks, errors);
    if (errors == 0 && tests_failed == 0) begin
      $display("Test passed");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== mem_init.hex ====
// One 16-bit word per line for word index 0 to 63
// High byte is the index, low byte its inverse
00FF
01FE
02FD
03FC
04FB
05FA
06F9
07F8
08F7
09F6
0AF5
0BF4
0CF3
0DF2
0EF1
0FF0
10EF
11EE
12ED
13EC
14EB
15EA
16E9
17E8
18E7
19E6
1AE5
1BE4
1CE3
1DE2
1EE1
1FE0
20DF
21DE
22DD
23DC
24DB
25DA
26D9
27D8
28D7
29D6
2AD5
2BD4
2CD3
2DD2
2ED1
2FD0
30CF
31CE
32CD
33CC
34CB
35CA
36C9
37C8
38C7
39C6
3AC5
3BC4
3CC3
3DC2
3EC1
3FC0

// ==== sources.f ====
axil_bridge_pkg.sv
skid_buf.sv
sync_fifo_zl.sv
axi_axil_reflect_rd.sv
axil_rd_mem.sv
axi_rd_bridge_top.sv
tb_axi_rd_bridge.sv

// ==== Bender.yml ====
package:
  name: axi_rd_bridge

sources:
  - axil_bridge_pkg.sv
  - skid_buf.sv
  - sync_fifo_zl.sv
  - axi_axil_reflect_rd.sv
  - axil_rd_mem.sv
  - axi_rd_bridge_top.sv
  - target: test
    files:
      - tb_axi_rd_bridge.sv
